// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j $(JOBS)
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(shell grep '\.sv$$' $(FLIST))
HDRS := $(wildcard *.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== branch_predecode.sv ====
`timescale 1ns/1ps
`include "fe_cfg.svh"

module branch_predecode (
  input  fe_pkg::addr_t  pc_i,
  input  fe_pkg::instr_t instr_i,
  output fe_pkg::cf_t    cf_o,
  output logic           taken_o,
  output fe_pkg::addr_t  predict_addr_o
);

  import fe_pkg::*;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic  is_branch;
  logic  is_jal;
  logic  is_jalr;
  addr_t imm_b;
  addr_t imm_j;
  addr_t imm;

  // ------------------------------------------------------------------------
  // opcode decode
  // ------------------------------------------------------------------------
  // funct3 010 and 011 are reserved for branches
  assign is_branch = (instr_i[6:0] == OPC_BRANCH) && (instr_i[14:13] != 2'b01);
  assign is_jal    = instr_i[6:0] == OPC_JAL;
  assign is_jalr   = (instr_i[6:0] == OPC_JALR) && (instr_i[14:12] == 3'b000);

  // B-type and J-type offsets, sign extended
  assign imm_b = {{(`FE_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{(`FE_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ------------------------------------------------------------------------
  // static prediction
  // ------------------------------------------------------------------------
  always_comb begin
    cf_o    = NONE;
    taken_o = 1'b0;
    imm     = imm_b;
    if (is_jal) begin
      cf_o    = JUMP;
      taken_o = 1'b1;
      imm     = imm_j;
    end else if (is_branch) begin
      cf_o    = BRANCH;
      // backward taken, forward not taken
      taken_o = imm_b[`FE_XLEN-1];
    end else if (is_jalr) begin
      // target lives in a register, keep fetching sequentially
      cf_o = JUMPR;
    end
  end

  assign predict_addr_o = taken_o ? pc_i + imm : pc_i + addr_t'(4);

  // only direct jumps and branches may redirect fetch
  always_comb begin
    if (taken_o) begin
      a_taken_direct: assert (cf_o inside {BRANCH, JUMP});
    end
  end

endmodule

// ==== fe_cfg.svh ====
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// ------------------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------------------
`define FE_XLEN 32

// thread count and fetch queue size
`define FE_NUM_THREADS 2
`define FE_QUEUE_DEPTH 4

// ------------------------------------------------------------------------
// boot addresses
// ------------------------------------------------------------------------
`define FE_BOOT_ADDR 32'h0000_0080
// thread n boots n strides above thread 0
`define FE_THREAD_STRIDE 32'h0000_0100
`endif

// ==== fe_pkg.sv ====
`include "fe_cfg.svh"

package fe_pkg;

  // program address and raw instruction word
  typedef logic [`FE_XLEN-1:0] addr_t;
  typedef logic [`FE_XLEN-1:0] instr_t;

  // thread index
  typedef logic [$clog2(`FE_NUM_THREADS)-1:0] thread_id_t;

  // control-flow class seen by the predecoder
  typedef enum logic [1:0] {
    NONE,
    BRANCH,
    JUMP,
    JUMPR
  } cf_t;

  // fetch eligibility of a thread
  typedef enum logic {
    READY,
    STALLED
  } thread_status_t;

  // one instruction on its way to decode
  typedef struct packed {
    thread_id_t thread;
    addr_t      pc;
    instr_t     instr;
    // address fetch continued at after this instruction
    addr_t      predict_addr;
    cf_t        cf;
  } fetch_entry_t;

endpackage

// ==== fetch_entry_if.sv ====
`timescale 1ns/1ps

interface fetch_entry_if;

  import fe_pkg::*;

  logic       valid;
  thread_id_t thread;
  addr_t      pc;
  instr_t     instr;
  addr_t      predict_addr;
  cf_t        cf;

  // response stage drives the predecoded instruction
  modport source (
    output valid, thread, pc, instr, predict_addr, cf
  );

  // fetch queue takes it
  modport sink (
    input valid, thread, pc, instr, predict_addr, cf
  );

endinterface

// ==== fetch_frontend.sv ====
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fetch_frontend (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // instruction cache request
  output logic                 icache_req_o,
  output fe_pkg::addr_t        icache_vaddr_o,
  output fe_pkg::thread_id_t   icache_thread_o,
  input  logic                 icache_ready_i,
  // response, one cycle after acceptance
  input  logic                 icache_valid_i,
  input  fe_pkg::instr_t       icache_data_i,
  // decode side
  output fe_pkg::fetch_entry_t fetch_entry_o,
  output logic                 fetch_valid_o,
  input  logic                 fetch_ready_i,
  // back-end redirect
  input  logic                 redirect_valid_i,
  input  fe_pkg::thread_id_t   redirect_thread_i,
  input  fe_pkg::addr_t        redirect_pc_i
);

  import fe_pkg::*;

  thread_id_t current;
  logic       accept;
  addr_t      pcs [`FE_NUM_THREADS];
  // request waiting for its response
  logic       inflight_valid_q;
  logic       inflight_killed_q;
  addr_t      inflight_pc_q;
  thread_id_t inflight_thread_q;
  // response stage
  logic       resp_live;
  cf_t        pd_cf;
  logic       pd_taken;
  addr_t      pd_addr;
  logic       queue_full;
  logic       queue_replay;
  logic       taken_kept;
  logic       kill_new;
  logic       consumed;

  fetch_entry_if entry_if ();

  // ------------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------------
  thread_sched i_thread_sched (
    .clk_i,
    .rst_ni,
    .queue_ready_i  (!queue_full),
    .icache_ready_i,
    .flush_i        (redirect_valid_i),
    .current_o      (current),
    .req_o          (icache_req_o)
  );

  assign accept          = icache_req_o && icache_ready_i;
  assign icache_vaddr_o  = pcs[current];
  assign icache_thread_o = current;

  // ------------------------------------------------------------------------
  // response side
  // ------------------------------------------------------------------------
  assign resp_live = inflight_valid_q && icache_valid_i && !inflight_killed_q &&
                     !redirect_valid_i;

  branch_predecode i_branch_predecode (
    .pc_i           (inflight_pc_q),
    .instr_i        (icache_data_i),
    .cf_o           (pd_cf),
    .taken_o        (pd_taken),
    .predict_addr_o (pd_addr)
  );

  assign entry_if.valid        = resp_live;
  assign entry_if.thread       = inflight_thread_q;
  assign entry_if.pc           = inflight_pc_q;
  assign entry_if.instr        = icache_data_i;
  assign entry_if.predict_addr = pd_addr;
  assign entry_if.cf           = pd_cf;

  assign taken_kept = resp_live && !queue_replay && pd_taken;
  // same-thread request issued next to a taken response is stale
  assign kill_new   = redirect_valid_i ||
                      (taken_kept && (current == inflight_thread_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_valid_q  <= 1'b0;
      inflight_killed_q <= 1'b0;
    end else begin
      inflight_valid_q  <= accept;
      inflight_killed_q <= kill_new;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      inflight_pc_q     <= icache_vaddr_o;
      inflight_thread_q <= current;
    end
  end

  // ------------------------------------------------------------------------
  // per-thread pcs
  // ------------------------------------------------------------------------
  assign consumed = fetch_valid_o && fetch_ready_i;

  for (genvar t = 0; t < `FE_NUM_THREADS; t++) begin : gen_thread_pc
    thread_pc i_thread_pc (
      .clk_i,
      .rst_ni,
      .boot_pc_i       (addr_t'(`FE_BOOT_ADDR + t * `FE_THREAD_STRIDE)),
      .advance_i       (accept && (current == thread_id_t'(t))),
      .predict_valid_i (taken_kept && (inflight_thread_q == thread_id_t'(t))),
      .predict_addr_i  (pd_addr),
      .replay_i        (queue_replay && (inflight_thread_q == thread_id_t'(t))),
      .replay_addr_i   (inflight_pc_q),
      .redirect_i      (redirect_valid_i && (redirect_thread_i == thread_id_t'(t))),
      .redirect_addr_i (redirect_pc_i),
      .resume_i        (redirect_valid_i && (redirect_thread_i != thread_id_t'(t))),
      .consumed_i      (consumed && (fetch_entry_o.thread == thread_id_t'(t))),
      .consumed_next_i (fetch_entry_o.predict_addr),
      .pc_o            (pcs[t])
    );
  end

  fetch_queue #(
    .DEPTH   (`FE_QUEUE_DEPTH),
    .entry_t (fetch_entry_t)
  ) i_fetch_queue (
    .clk_i,
    .rst_ni,
    .flush_i  (redirect_valid_i),
    .in       (entry_if),
    .ready_i  (fetch_ready_i),
    .replay_o (queue_replay),
    .entry_o  (fetch_entry_o),
    .valid_o  (fetch_valid_o),
    .full_o   (queue_full)
  );

  // the cache only answers a request accepted in the previous cycle
  a_resp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache_valid_i |-> inflight_valid_q);

endmodule

// ==== fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
  parameter int unsigned DEPTH   = 4,
  parameter type         entry_t = fe_pkg::fetch_entry_t
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  fetch_entry_if.sink in,
  input  logic        ready_i,
  output logic        replay_o,
  output entry_t      entry_o,
  output logic        valid_o,
  output logic        full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  entry_t           mem_q [DEPTH];
  entry_t           push_entry;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb begin
    push_entry.thread       = in.thread;
    push_entry.pc           = in.pc;
    push_entry.instr        = in.instr;
    push_entry.predict_addr = in.predict_addr;
    push_entry.cf           = in.cf;
  end

  assign full_o   = count_q == CNT_W'(DEPTH);
  assign valid_o  = count_q != '0;
  assign entry_o  = mem_q[rd_ptr_q];
  // an arrival at a full queue is dropped and sent back for refetch
  assign replay_o = in.valid && full_o && !flush_i;
  assign push     = in.valid && !full_o && !flush_i;
  assign pop      = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH));

  // empty with nothing arriving stays empty
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q == '0 && !in.valid |=> count_q == '0);

endmodule

// ==== fetch_stimulus.txt ====
// kind 1 program word: address, instruction, expected next pc
// kind 2 redirect: cycle, thread, target pc; kind 3 decode stall: first, last cycle
// thread 0, boots at 0x80
1 00000088 00208863 0000008c  // beq forward, not taken
1 00000090 0200006f 000000b0  // jal +0x20
1 000000b4 00008067 000000b8  // jalr falls through
1 000000b8 fc2098e3 00000088  // bne backward, taken
// thread 1, boots at 0x180
1 00000190 0400006f 000001d0  // jal +0x40
1 000001d4 0041c463 000001d8  // blt forward, not taken
1 000001e0 fa02d0e3 00000180  // bge backward, taken
// redirects
2 0000003c 00000000 00000084
2 0000006e 00000001 00000188  // lands inside the long stall
2 0000008c 00000001 00000400
// decode stalls
3 0000005a 00000082 00000000
3 000000aa 000000af 00000000

// ==== flist.f ====
+incdir+.
fe_pkg.sv
fetch_entry_if.sv
thread_pc.sv
thread_sched.sv
branch_predecode.sv
fetch_queue.sv
fetch_frontend.sv
tb_fetch_frontend.sv

// ==== tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`include "fe_cfg.svh"

module tb_fetch_frontend;

  import fe_pkg::*;

  localparam int STIM_WORDS = 256;
  // entries each thread must deliver after the last scheduled event
  localparam int GOAL = 12;

  logic         clk_i;
  logic         rst_ni;
  logic         icache_req_o;
  addr_t        icache_vaddr_o;
  thread_id_t   icache_thread_o;
  logic         icache_ready_i;
  logic         icache_valid_i;
  instr_t       icache_data_i;
  fetch_entry_t fetch_entry_o;
  logic         fetch_valid_o;
  logic         fetch_ready_i;
  logic         redirect_valid_i;
  thread_id_t   redirect_thread_i;
  addr_t        redirect_pc_i;

  // stimulus records and the tables built from them
  logic [31:0]  stim [STIM_WORDS];
  instr_t       prog_word [addr_t];
  addr_t        prog_next [addr_t];
  int           redir_cycle [$];
  thread_id_t   redir_thread [$];
  addr_t        redir_pc [$];
  int           stall_first [$];
  int           stall_last [$];
  int           num_records;
  int           last_event;
  int           limit;

  // run state
  integer       seed;
  int           cycle;
  logic         accepted;
  addr_t        accepted_addr;
  addr_t        exp_pc [`FE_NUM_THREADS];
  int           seen_after [`FE_NUM_THREADS];
  // thread named on the cache request for each fetched address
  thread_id_t   req_thread [addr_t];

  fetch_frontend i_fetch_frontend (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .icache_req_o      (icache_req_o),
    .icache_vaddr_o    (icache_vaddr_o),
    .icache_thread_o   (icache_thread_o),
    .icache_ready_i    (icache_ready_i),
    .icache_valid_i    (icache_valid_i),
    .icache_data_i     (icache_data_i),
    .fetch_entry_o     (fetch_entry_o),
    .fetch_valid_o     (fetch_valid_o),
    .fetch_ready_i     (fetch_ready_i),
    .redirect_valid_i  (redirect_valid_i),
    .redirect_thread_i (redirect_thread_i),
    .redirect_pc_i     (redirect_pc_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // memory model
  // --------------------------------------------------------------------------
  // plain ALU op for addresses the program leaves empty
  function automatic instr_t fill_word(input addr_t addr);
    return {addr[31:7] ^ {addr[6:0], addr[31:14]}, 7'h13};
  endfunction

  function automatic instr_t word_at(input addr_t addr);
    if (prog_word.exists(addr)) begin
      return prog_word[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic addr_t next_after(input addr_t addr);
    if (prog_next.exists(addr)) begin
      return prog_next[addr];
    end
    return addr + 32'd4;
  endfunction

  // control-flow class by RV32I opcode
  function automatic cf_t class_of(input instr_t word);
    case (word[6:0])
      7'b1100011: return BRANCH;
      7'b1101111: return JUMP;
      7'b1100111: return JUMPR;
      default:    return NONE;
    endcase
  endfunction

  function automatic logic in_stall(input int c);
    foreach (stall_first[i]) begin
      if (c >= stall_first[i] && c <= stall_last[i]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic logic goal_reached();
    return cycle > last_event && seen_after[0] >= GOAL && seen_after[1] >= GOAL;
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
    abort_run();
  endtask

  task automatic load_stimulus();
    logic [31:0] kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("fetch_stimulus.txt", stim);
    num_records = 0;
    last_event  = 0;
    for (int r = 0; r < STIM_WORDS / 4; r++) begin
      kind = stim[4*r];
      a    = stim[4*r+1];
      b    = stim[4*r+2];
      c    = stim[4*r+3];
      if (kind == 32'd0) begin
        break;
      end
      num_records++;
      case (kind)
        32'd1: begin
          prog_word[a] = b;
          prog_next[a] = c;
        end
        32'd2: begin
          redir_cycle.push_back(int'(a));
          redir_thread.push_back(thread_id_t'(b));
          redir_pc.push_back(c);
          last_event = (int'(a) > last_event) ? int'(a) : last_event;
        end
        32'd3: begin
          stall_first.push_back(int'(a));
          stall_last.push_back(int'(b));
          last_event = (int'(b) > last_event) ? int'(b) : last_event;
        end
        default: begin
          $display("Unknown record kind %0d in the stimulus file", kind);
          abort_run();
        end
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // checker
  // --------------------------------------------------------------------------
  task automatic check_entry(input fetch_entry_t e);
    addr_t want_pc;
    addr_t want_next;
    want_pc   = exp_pc[e.thread];
    want_next = next_after(want_pc);
    assert (e.pc == want_pc)
      else value_error("fetch_entry_o.pc", e.pc, want_pc);
    assert (req_thread.exists(e.pc))
      else begin
        $display("Entry at pc %h reached decode without a cache request", e.pc);
        abort_run();
      end
    assert (req_thread[e.pc] == e.thread)
      else value_error("icache_thread_o", req_thread[e.pc], e.thread);
    assert (e.instr == word_at(want_pc))
      else value_error("fetch_entry_o.instr", e.instr, word_at(want_pc));
    assert (e.cf == class_of(word_at(want_pc)))
      else value_error("fetch_entry_o.cf", e.cf, class_of(word_at(want_pc)));
    assert (e.predict_addr == want_next)
      else value_error("fetch_entry_o.predict_addr", e.predict_addr, want_next);
    exp_pc[e.thread] = want_next;
    if (cycle > last_event) begin
      seen_after[e.thread]++;
    end
  endtask

  // sampled mid-cycle where all inputs and outputs are settled
  always @(negedge clk_i) begin : monitor
    accepted      = rst_ni && icache_req_o && icache_ready_i;
    accepted_addr = icache_vaddr_o;
    if (accepted) begin
      req_thread[accepted_addr] = icache_thread_o;
    end
    if (rst_ni && fetch_valid_o && fetch_ready_i) begin
      check_entry(fetch_entry_o);
    end
    // the redirected thread restarts while the other keeps its expected pc
    if (rst_ni && redirect_valid_i) begin
      exp_pc[redirect_thread_i] = redirect_pc_i;
    end
  end

  // cache response, random misses, decode stalls and redirects
  always @(posedge clk_i) begin : drive
    logic [31:0] rnd;
    int          now;
    if (rst_ni) begin
      now              = cycle + 1;
      rnd              = $random(seed);
      cycle            <= now;
      icache_ready_i   <= rnd[1:0] != 2'b00;
      icache_valid_i   <= accepted;
      icache_data_i    <= word_at(accepted_addr);
      fetch_ready_i    <= !in_stall(now);
      redirect_valid_i <= 1'b0;
      foreach (redir_cycle[i]) begin
        if (redir_cycle[i] == now) begin
          redirect_valid_i  <= 1'b1;
          redirect_thread_i <= redir_thread[i];
          redirect_pc_i     <= redir_pc[i];
        end
      end
    end
  end

  initial begin : main
    rst_ni            = 1'b0;
    icache_ready_i    = 1'b0;
    icache_valid_i    = 1'b0;
    icache_data_i     = '0;
    fetch_ready_i     = 1'b0;
    redirect_valid_i  = 1'b0;
    redirect_thread_i = '0;
    redirect_pc_i     = '0;
    seed              = 11;
    cycle             = 0;
    accepted          = 1'b0;
    accepted_addr     = '0;
    exp_pc[0]         = `FE_BOOT_ADDR;
    exp_pc[1]         = `FE_BOOT_ADDR + 32'h100;
    seen_after[0]     = 0;
    seen_after[1]     = 0;
    load_stimulus();
    limit = 20 * num_records + 200;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (!goal_reached() && cycle < limit) begin
      @(posedge clk_i);
    end
    if (goal_reached()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Timeout after %0d cycles, the threads stopped delivering entries", cycle);
      abort_run();
    end
  end

endmodule

// ==== thread_pc.sv ====
`timescale 1ns/1ps

module thread_pc (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  fe_pkg::addr_t boot_pc_i,
  input  logic          advance_i,
  input  logic          predict_valid_i,
  input  fe_pkg::addr_t predict_addr_i,
  input  logic          replay_i,
  input  fe_pkg::addr_t replay_addr_i,
  input  logic          redirect_i,
  input  fe_pkg::addr_t redirect_addr_i,
  input  logic          resume_i,
  input  logic          consumed_i,
  input  fe_pkg::addr_t consumed_next_i,
  output fe_pkg::addr_t pc_o
);

  import fe_pkg::*;

  addr_t pc_q;
  addr_t pc_d;
  addr_t resume_q;
  addr_t resume_d;

  // pc after the last instruction decode accepted from this thread
  always_comb begin
    resume_d = resume_q;
    if (redirect_i) begin
      resume_d = redirect_addr_i;
    end else if (consumed_i) begin
      resume_d = consumed_next_i;
    end
  end

  // ------------------------------------------------------------------------
  // next fetch pc, highest priority first
  // ------------------------------------------------------------------------
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_addr_i;
    end else if (resume_i) begin
      // also covers an entry handed to decode in the flush cycle itself
      pc_d = resume_d;
    end else if (replay_i) begin
      pc_d = replay_addr_i;
    end else if (predict_valid_i) begin
      pc_d = predict_addr_i;
    end else if (advance_i) begin
      pc_d = pc_q + addr_t'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q     <= boot_pc_i;
      resume_q <= boot_pc_i;
    end else begin
      pc_q     <= pc_d;
      resume_q <= resume_d;
    end
  end

  assign pc_o = pc_q;

  // no source of a new pc may break word alignment
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_q[1:0] == 2'b00);

endmodule

// ==== thread_sched.sv ====
`timescale 1ns/1ps
`include "fe_cfg.svh"

module thread_sched (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               queue_ready_i,
  input  logic               icache_ready_i,
  input  logic               flush_i,
  output fe_pkg::thread_id_t current_o,
  output logic               req_o
);

  import fe_pkg::*;

  thread_status_t             status_q [`FE_NUM_THREADS];
  thread_status_t             status_d [`FE_NUM_THREADS];
  thread_id_t                 current_q;
  thread_id_t                 current_d;
  thread_id_t                 stalled_q;
  thread_id_t                 stalled_d;
  logic                       pending_q;
  logic                       pending_d;
  logic                       run_q;
  logic                       miss;
  logic [`FE_NUM_THREADS-1:0] stalled_vec;

  // nothing is issued in the cycle leaving reset
  assign req_o = run_q && queue_ready_i && (status_q[current_q] == READY);
  assign miss  = req_o && !icache_ready_i;

  // ------------------------------------------------------------------------
  // miss tracking
  // ------------------------------------------------------------------------
  always_comb begin
    status_d  = status_q;
    pending_d = pending_q;
    stalled_d = stalled_q;
    if (pending_q && icache_ready_i) begin
      status_d[stalled_q] = READY;
      pending_d           = 1'b0;
    end
    // a second miss while one is pending just retries
    if (miss && !pending_q) begin
      status_d[current_q] = STALLED;
      pending_d           = 1'b1;
      stalled_d           = current_q;
    end
    if (flush_i) begin
      for (int t = 0; t < `FE_NUM_THREADS; t++) begin
        status_d[t] = READY;
      end
      pending_d = 1'b0;
    end
  end

  // switch to the other thread whenever it may fetch
  always_comb begin
    current_d = current_q;
    if (status_q[~current_q] == READY) begin
      current_d = ~current_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int t = 0; t < `FE_NUM_THREADS; t++) begin
        status_q[t] <= READY;
      end
      current_q <= '0;
      stalled_q <= '0;
      pending_q <= 1'b0;
      run_q     <= 1'b0;
    end else begin
      status_q  <= status_d;
      current_q <= current_d;
      stalled_q <= stalled_d;
      pending_q <= pending_d;
      run_q     <= 1'b1;
    end
  end

  assign current_o = current_q;

  always_comb begin
    for (int t = 0; t < `FE_NUM_THREADS; t++) begin
      stalled_vec[t] = status_q[t] == STALLED;
    end
  end

  a_one_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $countones(stalled_vec) <= 1);

endmodule
